//--- design/alu_config.svh
//----------------------------------------------------------------------
// ALU build parameters
//----------------------------------------------------------------------

`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Datapath width
`define ALU_XLEN        32

// Shift amount taken from the low bits of op2
`define ALU_SHAMT_W     5

// One quotient bit per iteration
`define ALU_DIV_ITERS   `ALU_XLEN

`endif

//--- design/alu_pkg.sv
//----------------------------------------------------------------------
// ALU shared types
//----------------------------------------------------------------------

`default_nettype none

package alu_pkg;

    // Command set of the execution unit
    typedef enum logic [4:0] {
        CMD_ADD,
        CMD_SUB,
        CMD_AND,
        CMD_OR,
        CMD_XOR,
        CMD_SLT,
        CMD_SLTU,
        CMD_SEQ,
        CMD_SNE,
        CMD_SGE,
        CMD_SGEU,
        CMD_SLL,
        CMD_SRL,
        CMD_SRA,
        CMD_DIV,
        CMD_DIVU,
        CMD_REM,
        CMD_REMU
    } alu_cmd_e;

    // Main adder flags, taken from the subtraction for compares
    typedef struct packed {
        logic zero;         // Result all zeros
        logic sign;         // Result MSB
        logic overflow;     // Signed overflow
        logic carry;        // Carry out, borrow for sub
    } alu_flags_s;

    // Commands served by the iterative divider
    function automatic logic alu_is_div(alu_cmd_e cmd);
        return (cmd == CMD_DIV) || (cmd == CMD_DIVU) ||
               (cmd == CMD_REM) || (cmd == CMD_REMU);
    endfunction

endpackage

`default_nettype wire

//--- design/div_if.sv
//----------------------------------------------------------------------
// Divider request and answer bundle
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

interface div_if;

    logic                   start;      // One-cycle request pulse
    alu_pkg::alu_cmd_e      cmd;        // DIV, DIVU, REM or REMU
    logic [`ALU_XLEN-1:0]   dividend;   // Held stable until done
    logic [`ALU_XLEN-1:0]   divisor;
    logic                   done;       // One-cycle answer pulse
    logic [`ALU_XLEN-1:0]   result;     // Quotient or remainder, valid with done

    // Requesting side
    modport issue (
        output start, cmd, dividend, divisor,
        input  done, result
    );

    // Divider side
    modport div (
        input  start, cmd, dividend, divisor,
        output done, result
    );

endinterface

`default_nettype wire

//--- design/alu_basic.sv
//----------------------------------------------------------------------
// ALU single-cycle operations
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module alu_basic (
    input  wire alu_pkg::alu_cmd_e      cmd_i,
    input  wire logic [`ALU_XLEN-1:0]   op1_i,
    input  wire logic [`ALU_XLEN-1:0]   op2_i,
    output logic [`ALU_XLEN-1:0]        res_o,
    output logic                        cmp_o
);

    localparam int W = `ALU_XLEN;

    logic                       is_add;
    logic [W:0]                 sum;        // MSB is carry/borrow
    logic                       op2_eff_s;  // op2 sign as seen by the adder
    alu_pkg::alu_flags_s        flags;
    logic                       lt;         // Signed less-than
    logic [`ALU_SHAMT_W-1:0]    shamt;
    logic [W-1:0]               shft_res;

    //------------------------------------------------------------------
    // Main adder, subtracts unless ADD
    //------------------------------------------------------------------
    assign is_add    = (cmd_i == alu_pkg::CMD_ADD);
    assign sum       = is_add ? ({1'b0, op1_i} + {1'b0, op2_i})
                              : ({1'b0, op1_i} - {1'b0, op2_i});
    assign op2_eff_s = op2_i[W-1] ^ ~is_add;

    always_comb begin
        flags.carry    = sum[W];
        flags.zero     = ~|sum[W-1:0];
        flags.sign     = sum[W-1];
        // Same operand signs but result sign flipped
        flags.overflow = (op1_i[W-1] == op2_eff_s) & (sum[W-1] != op1_i[W-1]);
    end

    assign lt = flags.sign ^ flags.overflow;

    //------------------------------------------------------------------
    // Shifter
    //------------------------------------------------------------------
    assign shamt = op2_i[`ALU_SHAMT_W-1:0];

    always_comb begin
        case (cmd_i)
            alu_pkg::CMD_SRL: shft_res = op1_i >> shamt;
            alu_pkg::CMD_SRA: shft_res = $signed(op1_i) >>> shamt;  // Sign fill
            default:          shft_res = op1_i << shamt;
        endcase
    end

    //------------------------------------------------------------------
    // Result select
    //------------------------------------------------------------------
    always_comb begin
        cmp_o = 1'b0;
        res_o = '0;
        case (cmd_i)
            alu_pkg::CMD_ADD,
            alu_pkg::CMD_SUB:  res_o = sum[W-1:0];
            alu_pkg::CMD_AND:  res_o = op1_i & op2_i;
            alu_pkg::CMD_OR:   res_o = op1_i | op2_i;
            alu_pkg::CMD_XOR:  res_o = op1_i ^ op2_i;
            alu_pkg::CMD_SLT:  cmp_o = lt;
            alu_pkg::CMD_SLTU: cmp_o = flags.carry;     // Borrow means op1 < op2
            alu_pkg::CMD_SEQ:  cmp_o = flags.zero;
            alu_pkg::CMD_SNE:  cmp_o = ~flags.zero;
            alu_pkg::CMD_SGE:  cmp_o = ~lt;
            alu_pkg::CMD_SGEU: cmp_o = ~flags.carry;
            alu_pkg::CMD_SLL,
            alu_pkg::CMD_SRL,
            alu_pkg::CMD_SRA:  res_o = shft_res;
            default:           res_o = '0;              // DIV/REM handled elsewhere
        endcase
        if (cmp_o) begin
            res_o = {{(W-1){1'b0}}, 1'b1};              // Zero-extended outcome
        end
    end

endmodule

`default_nettype wire

//--- design/alu_issue.sv
//----------------------------------------------------------------------
// ALU issue stage
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module alu_issue (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   cmd_vld_i,
    output logic                        cmd_rdy_o,
    input  wire alu_pkg::alu_cmd_e      cmd_i,
    input  wire logic [`ALU_XLEN-1:0]   op1_i,
    input  wire logic [`ALU_XLEN-1:0]   op2_i,
    input  wire logic [`ALU_XLEN-1:0]   basic_res_i,    // From alu_basic
    input  wire logic                   basic_cmp_i,
    output logic                        res_vld_o,
    output logic [`ALU_XLEN-1:0]        res_o,
    output logic                        cmp_o,
    output alu_pkg::alu_cmd_e           cmd_o,          // To alu_basic
    output logic [`ALU_XLEN-1:0]        op1_o,
    output logic [`ALU_XLEN-1:0]        op2_o,
    div_if.issue                        div_bus
);

    alu_pkg::alu_cmd_e      cmd_q;
    logic [`ALU_XLEN-1:0]   op1_q;
    logic [`ALU_XLEN-1:0]   op2_q;

    logic   busy_q;         // Command in flight
    logic   basic_pend_q;   // Basic result ready this cycle
    logic   start_q;        // Divider request pulse
    logic   accept;
    logic   finish;         // Result to capture on this edge

    //------------------------------------------------------------------
    // Handshake
    //------------------------------------------------------------------
    assign cmd_rdy_o = ~busy_q;                    // One command at a time
    assign accept    = cmd_vld_i & cmd_rdy_o;
    assign finish    = basic_pend_q | div_bus.done;

    // Input register, held for the whole command
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd_i;
            op1_q <= op1_i;
            op2_q <= op2_i;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            busy_q       <= 1'b0;
            basic_pend_q <= 1'b0;
            start_q      <= 1'b0;
            res_vld_o    <= 1'b0;
        end else begin
            busy_q       <= accept | (busy_q & ~finish);   // Free again with res_vld_o
            basic_pend_q <= accept & ~alu_pkg::alu_is_div(cmd_i);
            start_q      <= accept &  alu_pkg::alu_is_div(cmd_i);
            res_vld_o    <= finish;                        // Single pulse
        end
    end

    //------------------------------------------------------------------
    // Output register
    //------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (finish) begin
            res_o <= basic_pend_q ? basic_res_i : div_bus.result;
            cmp_o <= basic_pend_q & basic_cmp_i;  // No compare for DIV/REM
        end
    end

    // Registered command to the datapaths
    assign cmd_o = cmd_q;
    assign op1_o = op1_q;
    assign op2_o = op2_q;

    assign div_bus.start    = start_q;
    assign div_bus.cmd      = cmd_q;
    assign div_bus.dividend = op1_q;   // Stable until done
    assign div_bus.divisor  = op2_q;

endmodule

`default_nettype wire

//--- design/alu_divider.sv
//----------------------------------------------------------------------
// Non-restoring divider
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module alu_divider (
    input  wire logic   clk,
    input  wire logic   rst_n,
    div_if.div          div_bus
);

    localparam int W  = `ALU_XLEN;
    localparam int NI = `ALU_DIV_ITERS;

    // First iteration runs in the start cycle, so count one less
    localparam logic [NI-1:0] CNT_INIT = {{(NI-1){1'b0}}, 1'b1} << (NI - 2);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITER,
        ST_CORR
    } state_e;

    state_e         state_q;
    state_e         state_d;
    logic [NI-1:0]  cnt_q;          // One-hot countdown
    logic [NI-1:0]  cnt_d;

    logic           st_idle;
    logic           st_iter;
    logic           st_corr;
    logic           is_rem;         // REM or REMU
    logic           ops_sgn;        // DIV or REM
    logic           op1_neg;
    logic           op2_neg;
    logic           diff_sgn;       // Operand MSBs differ
    logic           ops_nz;         // Neither operand zero
    logic           iter_last;
    logic           corr_req;
    logic           upd;

    logic           sum_sgn;
    logic           sum_sub;        // 1 subtract, 0 add
    logic [W:0]     sum_op1;
    logic [W:0]     sum_op2;
    logic [W:0]     sum_res;

    logic           rem_c;          // Partial remainder sign
    logic [W-1:0]   rem;
    logic [W-1:0]   quo;
    logic           quo_bit;
    logic [W-1:0]   dlo_d;          // Dividend bits still to shift in

    logic           rem_c_q;
    logic [W-1:0]   rem_q;
    logic [W-1:0]   quo_q;
    logic [W-1:0]   dlo_q;

    //------------------------------------------------------------------
    // Command decode
    //------------------------------------------------------------------
    assign st_idle  = (state_q == ST_IDLE);
    assign st_iter  = (state_q == ST_ITER);
    assign st_corr  = (state_q == ST_CORR);
    assign is_rem   = (div_bus.cmd == alu_pkg::CMD_REM) | (div_bus.cmd == alu_pkg::CMD_REMU);
    assign ops_sgn  = (div_bus.cmd == alu_pkg::CMD_DIV) | (div_bus.cmd == alu_pkg::CMD_REM);
    assign op1_neg  = ops_sgn & div_bus.dividend[W-1];
    assign op2_neg  = ops_sgn & div_bus.divisor[W-1];
    assign diff_sgn = div_bus.dividend[W-1] ^ div_bus.divisor[W-1];
    assign ops_nz   = (|div_bus.dividend) & (|div_bus.divisor);

    assign iter_last = cnt_q[0];
    // Signed quotient negated, or remainder sign fixed up
    assign corr_req  = ((div_bus.cmd == alu_pkg::CMD_DIV) & diff_sgn)
                     | (is_rem & (|rem) & (op1_neg ^ rem_c));

    //------------------------------------------------------------------
    // Shared adder/subtractor
    //------------------------------------------------------------------
    always_comb begin
        sum_sgn = st_corr ? (op1_neg ^ rem_c_q)     // Remainder sign wrong
                : st_idle ? 1'b0
                          : ~quo_q[0];              // Previous quotient bit
        sum_sub = ~(ops_sgn & diff_sgn) ^ sum_sgn;
        sum_op1 = st_corr ? {1'b0, rem_q}
                : st_idle ? {{W{op1_neg}}, div_bus.dividend[W-1]}
                          : {rem_q, dlo_q[W-1]};
        sum_op2 = {op2_neg, div_bus.divisor};
        sum_res = sum_sub ? (sum_op1 - sum_op2) : (sum_op1 + sum_op2);
    end

    // Quotient bit, with the exact-zero case for negative dividends
    always_comb begin
        rem_c   = sum_res[W];
        rem     = sum_res[W-1:0];
        dlo_d   = st_idle ? (div_bus.dividend << 1) : (dlo_q << 1);
        quo_bit = ~(op1_neg ^ rem_c) | (op1_neg & ({sum_res, dlo_d} == '0));
        quo     = st_idle ? {{(W-1){1'b0}}, quo_bit} : {quo_q[W-2:0], quo_bit};
    end

    //------------------------------------------------------------------
    // FSM and countdown
    //------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (div_bus.start & ops_nz) state_d = ST_ITER;
            ST_ITER: if (iter_last) state_d = corr_req ? ST_CORR : ST_IDLE;
            default: state_d = ST_IDLE;                 // Correction is one cycle
        endcase
    end

    assign cnt_d = st_idle ? CNT_INIT : (cnt_q >> 1);
    assign upd   = (st_idle & div_bus.start) | st_iter;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (upd) begin
                cnt_q <= cnt_d;
            end
        end
    end

    // Remainder, quotient and dividend-low registers
    always_ff @(posedge clk) begin
        if (upd) begin
            rem_c_q <= rem_c;
            rem_q   <= rem;
            quo_q   <= quo;
            dlo_q   <= dlo_d;
        end
    end

    //------------------------------------------------------------------
    // Answer
    //------------------------------------------------------------------
    always_comb begin
        case (state_q)
            ST_ITER: begin
                div_bus.result = is_rem ? rem : quo;
                div_bus.done   = iter_last & ~corr_req;
            end
            ST_CORR: begin
                div_bus.result = is_rem ? sum_res[W-1:0] : -quo_q;
                div_bus.done   = 1'b1;
            end
            default: begin
                // Zero shortcut: x/0 all ones, x%0 and 0/x give the dividend
                div_bus.result = ((|div_bus.divisor) | is_rem) ? div_bus.dividend : '1;
                div_bus.done   = div_bus.start & ~ops_nz;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/alu_top.sv
//----------------------------------------------------------------------
// Integer execution unit top
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module alu_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   cmd_vld_i,  // Command request
    output logic                        cmd_rdy_o,  // Unit can take a command
    input  wire alu_pkg::alu_cmd_e      cmd_i,
    input  wire logic [`ALU_XLEN-1:0]   op1_i,
    input  wire logic [`ALU_XLEN-1:0]   op2_i,
    output logic                        res_vld_o,  // One pulse per command
    output logic [`ALU_XLEN-1:0]        res_o,
    output logic                        cmp_o       // Compare outcome
);

    alu_pkg::alu_cmd_e      cmd_q;      // Registered command
    logic [`ALU_XLEN-1:0]   op1_q;
    logic [`ALU_XLEN-1:0]   op2_q;
    logic [`ALU_XLEN-1:0]   basic_res;
    logic                   basic_cmp;

    div_if div_bus ();

    //------------------------------------------------------------------
    // Input/output registers and dispatch
    //------------------------------------------------------------------
    alu_issue u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_vld_i   (cmd_vld_i),
        .cmd_rdy_o   (cmd_rdy_o),
        .cmd_i       (cmd_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .basic_res_i (basic_res),
        .basic_cmp_i (basic_cmp),
        .res_vld_o   (res_vld_o),
        .res_o       (res_o),
        .cmp_o       (cmp_o),
        .cmd_o       (cmd_q),
        .op1_o       (op1_q),
        .op2_o       (op2_q),
        .div_bus     (div_bus.issue)
    );

    // Single-cycle ops on the registered operands
    alu_basic u_basic (
        .cmd_i (cmd_q),
        .op1_i (op1_q),
        .op2_i (op2_q),
        .res_o (basic_res),
        .cmp_o (basic_cmp)
    );

    // Iterative DIV/REM
    alu_divider u_divider (
        .clk     (clk),
        .rst_n   (rst_n),
        .div_bus (div_bus.div)
    );

endmodule

`default_nettype wire

//--- dv/alu_tb.sv
//----------------------------------------------------------------------
// ALU testbench
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module alu_tb;

    localparam int W            = `ALU_XLEN;
    localparam int SH           = `ALU_SHAMT_W;
    localparam int NUM_CMD      = int'(alu_pkg::CMD_REMU) + 1;
    localparam int NUM_CORNER   = 6;
    localparam int NUM_DIRECTED = NUM_CMD * NUM_CORNER * NUM_CORNER;
    localparam int NUM_RANDOM   = 3000;
    localparam int NUM_TOTAL    = NUM_DIRECTED + NUM_RANDOM;
    localparam int TIMEOUT_CYC  = NUM_TOTAL * (`ALU_DIV_ITERS + 8) + 100;

    // Carry, overflow, sign and shift corners
    localparam logic [W-1:0] CORNERS [NUM_CORNER] = '{
        {W{1'b0}},
        W'(1),
        W'((1 << SH) - 1),              // Largest shift amount
        {1'b0, {(W-1){1'b1}}},          // Max signed
        {1'b1, {(W-1){1'b0}}},          // Min signed
        {W{1'b1}}                       // Minus one
    };

    typedef struct packed {
        alu_pkg::alu_cmd_e  cmd;
        logic [W-1:0]       a;
        logic [W-1:0]       b;
        logic [W-1:0]       res;
        logic               cmp;
        logic               is_div;
        int unsigned        acc;        // Acceptance edge
    } exp_t;

    logic               clk;
    logic               rst_n;
    logic               cmd_vld_i;
    logic               cmd_rdy_o;
    alu_pkg::alu_cmd_e  cmd_i;
    logic [W-1:0]       op1_i;
    logic [W-1:0]       op2_i;
    logic               res_vld_o;
    logic [W-1:0]       res_o;
    logic               cmp_o;

    exp_t               exp_q [$];      // Commands in flight, oldest first
    int unsigned        cyc = 0;        // Rising edges so far
    int                 n_done = 0;
    integer             seed = 32'h218a5375;

    alu_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_vld_i (cmd_vld_i),
        .cmd_rdy_o (cmd_rdy_o),
        .cmd_i     (cmd_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .res_vld_o (res_vld_o),
        .res_o     (res_o),
        .cmp_o     (cmp_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    //------------------------------------------------------------------
    // Reference model, RISC-V integer rules
    //------------------------------------------------------------------
    function automatic logic [W:0] ref_model(alu_pkg::alu_cmd_e cmd,
                                              logic [W-1:0] a, logic [W-1:0] b);
        logic signed [W-1:0]    sa;
        logic signed [W-1:0]    sb;
        logic [W-1:0]           res;
        logic                   cmp;
        logic                   ovf;
        sa  = a;
        sb  = b;
        res = '0;
        cmp = 1'b0;
        ovf = (a == CORNERS[4]) && (b == CORNERS[5]);   // MIN / -1
        case (cmd)
            alu_pkg::CMD_ADD:  res = a + b;
            alu_pkg::CMD_SUB:  res = a - b;
            alu_pkg::CMD_AND:  res = a & b;
            alu_pkg::CMD_OR:   res = a | b;
            alu_pkg::CMD_XOR:  res = a ^ b;
            alu_pkg::CMD_SLT:  cmp = sa < sb;
            alu_pkg::CMD_SLTU: cmp = a < b;
            alu_pkg::CMD_SEQ:  cmp = a == b;
            alu_pkg::CMD_SNE:  cmp = a != b;
            alu_pkg::CMD_SGE:  cmp = sa >= sb;
            alu_pkg::CMD_SGEU: cmp = a >= b;
            alu_pkg::CMD_SLL:  res = a << b[SH-1:0];
            alu_pkg::CMD_SRL:  res = a >> b[SH-1:0];
            alu_pkg::CMD_SRA:  res = sa >>> b[SH-1:0];
            alu_pkg::CMD_DIV: begin
                if (b == '0) begin
                    res = '1;
                end else if (ovf) begin
                    res = a;            // MIN / -1 keeps the dividend
                end else begin
                    res = sa / sb;      // Signed, rounds toward zero
                end
            end
            alu_pkg::CMD_DIVU: res = (b == '0) ? '1 : a / b;
            alu_pkg::CMD_REM: begin
                if (b == '0) begin
                    res = a;
                end else if (ovf) begin
                    res = '0;
                end else begin
                    res = sa % sb;      // Sign follows the dividend
                end
            end
            alu_pkg::CMD_REMU: res = (b == '0) ? a : a % b;
            default:           res = '0;
        endcase
        if (cmp) begin
            res = W'(1);                // Compare outcome zero-extended
        end
        return {cmp, res};
    endfunction

    //------------------------------------------------------------------
    // Error handling and checks
    //------------------------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_val(input string what, input logic [W-1:0] got,
                             input logic [W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s, got %h expected %h",
                                    $time, what, got, exp));
        end
    endtask

    function automatic logic [W-1:0] rand_operand();
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] == 3'd0) begin
            return CORNERS[r[5:3] % NUM_CORNER];    // Corner one time in eight
        end
        return $random(seed);
    endfunction

    // Waits for ready, drives one command and queues its expected result
    task automatic issue_cmd(input alu_pkg::alu_cmd_e cmd, input logic [W-1:0] a,
                             input logic [W-1:0] b, input int gap);
        exp_t       e;
        logic [W:0] r;
        @(negedge clk);
        cmd_vld_i = 1'b0;
        repeat (gap) @(negedge clk);
        while (!cmd_rdy_o) @(negedge clk);
        cmd_i     = cmd;
        op1_i     = a;
        op2_i     = b;
        cmd_vld_i = 1'b1;
        r         = ref_model(cmd, a, b);
        e.cmd     = cmd;
        e.a       = a;
        e.b       = b;
        e.res     = r[W-1:0];
        e.cmp     = r[W];
        e.is_div  = alu_pkg::alu_is_div(cmd);
        e.acc     = cyc + 1;            // Taken on the coming rising edge
        exp_q.push_back(e);
    endtask

    //------------------------------------------------------------------
    // Compare process, samples on the falling edge
    //------------------------------------------------------------------
    always @(negedge clk) begin : compare_results
        exp_t e;
        if (rst_n) begin
            // Low while busy, back high with the result pulse
            if (exp_q.size() != 0 && exp_q[0].acc <= cyc) begin
                check_val("cmd_rdy_o while a command is in flight",
                          W'(cmd_rdy_o), W'(res_vld_o));
            end
            if (res_vld_o) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("A result pulse came with no command in flight");
                end
                e = exp_q.pop_front();
                check_val($sformatf("%s res_o a=%h b=%h", e.cmd.name(), e.a, e.b),
                          res_o, e.res);
                check_val($sformatf("%s cmp_o a=%h b=%h", e.cmd.name(), e.a, e.b),
                          W'(cmp_o), W'(e.cmp));
                if (!e.is_div) begin
                    check_val("basic result edge", W'(cyc), W'(e.acc + 1));
                end
                n_done++;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            stop_on_error($sformatf("The run timed out after %0d clock cycles", cyc));
        end
    end

    //------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------
    initial begin
        logic [31:0]    r;
        logic [W-1:0]   a;
        logic [W-1:0]   b;
        int             gap;
        int             c;
        rst_n     = 1'b0;
        cmd_vld_i = 1'b0;
        cmd_i     = alu_pkg::CMD_ADD;
        op1_i     = '0;
        op2_i     = '0;
        repeat (16) begin
            @(negedge clk);
            check_val("cmd_rdy_o in reset", W'(cmd_rdy_o), W'(1));
            check_val("res_vld_o in reset", W'(res_vld_o), '0);
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_val("cmd_rdy_o after reset", W'(cmd_rdy_o), W'(1));
            check_val("res_vld_o after reset", W'(res_vld_o), '0);
        end

        // Every command on every corner pair
        for (int k = 0; k < NUM_CMD; k++) begin
            for (int i = 0; i < NUM_CORNER; i++) begin
                for (int j = 0; j < NUM_CORNER; j++) begin
                    issue_cmd(alu_pkg::alu_cmd_e'(k[4:0]), CORNERS[i], CORNERS[j], 0);
                end
            end
        end

        // Random mix, mostly back to back
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r   = $random(seed);
            a   = rand_operand();
            b   = (r[3:0] == 4'd0) ? a : rand_operand();   // Equal pairs
            gap = (r[9:8] == 2'd0) ? int'(r[11:10]) : 0;
            c   = int'(r[31:16]) % NUM_CMD;
            issue_cmd(alu_pkg::alu_cmd_e'(c[4:0]), a, b, gap);
        end
        @(negedge clk);
        cmd_vld_i = 1'b0;

        while (exp_q.size() != 0) @(negedge clk);
        repeat (5) @(negedge clk);      // No stray result pulses
        if (exp_q.size() == 0 && n_done == NUM_TOTAL) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_on_error("The number of results does not match the commands issued");
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/alu_pkg.sv
design/div_if.sv
design/alu_basic.sv
design/alu_issue.sv
design/alu_divider.sv
design/alu_top.sv
dv/alu_tb.sv

//--- Makefile
# Verilator build and run of the ALU testbench

TOP := alu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
